/* verilog/fetch_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared widths, address, ID and instruction types, the buffered
// request and the sequencer state encoding of the block fetcher
//////////////////////////////////////////////////////////////////////

package fetch_pkg;

    // Address bus width toward the cache and the memory controller
    localparam int ADDR_W = 32;
    // Request ID width, returned with each response
    localparam int ID_W = 8;
    // Instruction width, whatever the architecture
    localparam int ILEN = 32;
    // Bytes per cache block, a memory read always covers a whole block
    localparam int BLOCK_BYTES = 16;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [ILEN-1:0]   instr_t;

    // One buffered read request
    typedef struct packed {
        addr_t addr;
        id_t   id;
    } fetch_req_t;

    // Sequencer states
    // IDLE waits for new requests, FETCH serves them,
    // LOAD waits for the refill, MISSED replays parked requests
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        FETCH  = 2'd1,
        MISSED = 2'd2,
        LOAD   = 2'd3
    } seq_state_t;

endpackage

/* verilog/lookup_if.sv */
//////////////////////////////////////////////////////////////////////
// Lookup stage shared by the sequencer, the completion and the loader
//////////////////////////////////////////////////////////////////////

interface lookup_if
    import fetch_pkg::*;
();

    // Request presented to the cache on the previous cycle
    addr_t lk_addr;
    id_t   lk_id;
    // Set from a miss up to the refill, late lookups get parked
    logic  miss_pending;

    // Cache answer for the registered lookup
    logic  hit;
    logic  miss;
    // Refill strobe of the missed block
    logic  fill;

    // Memory read accepted, refill not yet written
    logic  loading;

    modport seq (
        output lk_addr, lk_id, miss_pending,
        input  hit, miss, fill, loading
    );

    modport cpl (
        input  lk_id, hit, miss_pending
    );

    modport ldr (
        input  lk_addr, lk_id, miss, fill,
        output loading
    );

endinterface

/* verilog/sync_fifo.sv */
//////////////////////////////////////////////////////////////////////
// Single clock request FIFO, optional pass-through and flush
//////////////////////////////////////////////////////////////////////

module sync_fifo
    import fetch_pkg::*;
#(
    parameter int DEPTH     = 4,
    parameter int PASS_THRU = 0
)(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       flush,
    input  fetch_req_t data_in,
    input  logic       push,
    output logic       full,
    output fetch_req_t data_out,
    input  logic       pull,
    output logic       empty
);

    localparam int PTR_W = $clog2(DEPTH);

    // Pointers carry one wrap bit above the index
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           buf_empty;

    fetch_req_t mem [DEPTH];

    //////////////////////////////////////////////////////////////////
    // Pointers
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage, written on every push even when passed through
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= data_in;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Status and read port
    //////////////////////////////////////////////////////////////////

    assign buf_empty = (wr_ptr == rd_ptr);
    // Same index, different lap
    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // In pass-through a push into an empty buffer is readable at once
    assign empty = buf_empty && !((PASS_THRU != 0) && push);
    assign data_out = ((PASS_THRU != 0) && buf_empty) ? data_in
                                                       : mem[rd_ptr[PTR_W-1:0]];

    // Callers must respect full and empty
    push_not_full: assert property (@(posedge aclk) disable iff (!aresetn)
        push && !flush |-> !full);
    pull_not_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        pull && !flush |-> !empty);

endmodule

/* verilog/fetch_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// Request and missed-request FIFOs, cache read mux, lookup register
// and the sequencer FSM that orders new and replayed lookups
//////////////////////////////////////////////////////////////////////

module fetch_sequencer
    import fetch_pkg::*;
#(
    parameter int OSTDREQ_NUM = 4,
    parameter int MF_DEPTH    = 8
)(
    input  logic   aclk,
    input  logic   aresetn,
    input  logic   flush_reqs,
    input  logic   arvalid,
    output logic   arready,
    input  addr_t  araddr,
    input  id_t    arid,
    input  logic   rready,
    output logic   cache_ren,
    output addr_t  cache_raddr,
    output logic   pending_rd,
    lookup_if.seq  lk
);

    seq_state_t state;

    // New request FIFO
    fetch_req_t req_in;
    fetch_req_t req_head;
    logic       req_push;
    logic       req_pull;
    logic       req_full;
    logic       req_empty;
    // Missed request FIFO
    fetch_req_t mf_in;
    fetch_req_t mf_head;
    logic       mf_push;
    logic       mf_pull;
    logic       mf_full;
    logic       mf_empty;

    fetch_req_t cur_req;
    logic       can_issue;
    logic       issue_new;
    logic       issue_mf;
    // Registered lookup came from the missed FIFO
    logic       lk_mf;

    //////////////////////////////////////////////////////////////////
    // Buffering
    //////////////////////////////////////////////////////////////////

    assign req_in   = '{addr: araddr, id: arid};
    assign req_push = arvalid && arready;
    // No new request accepted while flushing
    assign arready  = !req_full && !flush_reqs;

    sync_fifo #(
        .DEPTH     (OSTDREQ_NUM),
        .PASS_THRU (1)
    ) req_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .flush    (flush_reqs),
        .data_in  (req_in),
        .push     (req_push),
        .full     (req_full),
        .data_out (req_head),
        .pull     (req_pull),
        .empty    (req_empty)
    );

    // Park a new lookup that missed, or that hit behind a pending miss
    assign mf_in   = '{addr: lk.lk_addr, id: lk.lk_id};
    assign mf_push = !lk_mf && (lk.miss || (lk.hit && lk.miss_pending));
    // Replayed entry stays at the head until it hits
    assign mf_pull = lk_mf && lk.hit;

    sync_fifo #(
        .DEPTH     (MF_DEPTH),
        .PASS_THRU (0)
    ) miss_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .flush    (flush_reqs),
        .data_in  (mf_in),
        .push     (mf_push),
        .full     (mf_full),
        .data_out (mf_head),
        .pull     (mf_pull),
        .empty    (mf_empty)
    );

    //////////////////////////////////////////////////////////////////
    // Cache read issue
    //////////////////////////////////////////////////////////////////

    // Never read while the response path is stalled or a refill runs
    assign can_issue = rready && !flush_reqs && !lk.loading;
    // New requests only once every parked one is served
    assign issue_new = ((state == IDLE) || (state == FETCH)) &&
                       mf_empty && !req_empty && !mf_full;
    // Replay one parked request at a time, wait for its answer
    assign issue_mf  = (state == MISSED) && !mf_empty && !lk_mf;

    assign cache_ren = can_issue && (issue_new || issue_mf);
    assign req_pull  = can_issue && issue_new;

    // Parked requests win the mux
    assign cur_req     = mf_empty ? req_head : mf_head;
    assign cache_raddr = cur_req.addr;

    assign pending_rd = !mf_empty || lk.loading;

    // Lookup stage, the cache answers one cycle later
    always_ff @(posedge aclk) begin
        lk.lk_addr <= cur_req.addr;
        lk.lk_id   <= cur_req.id;
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lk_mf           <= 1'b0;
            lk.miss_pending <= 1'b0;
        end else begin
            lk_mf <= cache_ren && issue_mf;
            if (flush_reqs || lk.fill) begin
                lk.miss_pending <= 1'b0;
            end else if (lk.miss) begin
                lk.miss_pending <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Sequencer FSM
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= IDLE;
        end else if (flush_reqs) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (!req_empty && !lk.loading) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    // Stop on the first miss and wait for the refill
                    if (lk.miss) begin
                        state <= LOAD;
                    end else if (req_empty) begin
                        state <= IDLE;
                    end
                end
                MISSED: begin
                    if (lk_mf && lk.miss) begin
                        state <= LOAD;
                    end else if (mf_empty) begin
                        state <= req_empty ? IDLE : FETCH;
                    end
                end
                LOAD: begin
                    // Replay starts the cycle after the refill strobe
                    if (lk.fill) begin
                        state <= MISSED;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    no_read_in_load: assert property (@(posedge aclk) disable iff (!aresetn)
        state == LOAD |-> !cache_ren);

endmodule

/* verilog/read_completion.sv */
//////////////////////////////////////////////////////////////////////
// Read data channel with a hold register under back-pressure
//////////////////////////////////////////////////////////////////////

module read_completion
    import fetch_pkg::*;
(
    input  logic   aclk,
    input  logic   aresetn,
    input  logic   rready,
    input  instr_t cache_rdata,
    output logic   rvalid,
    output id_t    rid,
    output instr_t rdata,
    lookup_if.cpl  lk
);

    // Response not accepted on its first cycle
    logic   hold_valid;
    instr_t hold_data;
    id_t    hold_id;

    //////////////////////////////////////////////////////////////////
    // Hold register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= rvalid && !rready;
        end
    end

    // Track the live response until one gets stuck
    always_ff @(posedge aclk) begin
        if (!hold_valid) begin
            hold_data <= cache_rdata;
            hold_id   <= lk.lk_id;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Response outputs
    //////////////////////////////////////////////////////////////////

    // Hits behind a pending miss are parked, not returned
    assign rvalid = (lk.hit && !lk.miss_pending) || hold_valid;
    assign rdata  = hold_valid ? hold_data : cache_rdata;
    assign rid    = hold_valid ? hold_id : lk.lk_id;

    // A stalled response keeps its payload up to the handshake
    resp_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid));

endmodule

/* verilog/block_loader.sv */
//////////////////////////////////////////////////////////////////////
// Memory controller read for a missed block and the loading flag
//////////////////////////////////////////////////////////////////////

module block_loader
    import fetch_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  flush_reqs,
    output logic  mem_arvalid,
    input  logic  mem_arready,
    output addr_t mem_araddr,
    output id_t   mem_arid,
    lookup_if.ldr lk
);

    // Byte offset inside a block
    localparam addr_t OFFSET_MASK = addr_t'(BLOCK_BYTES - 1);

    logic issue;

    // One block read at a time, later misses of a burst are ignored
    assign issue = lk.miss && !mem_arvalid && !lk.loading && !flush_reqs;

    //////////////////////////////////////////////////////////////////
    // Memory request
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mem_arvalid <= 1'b0;
        end else if (flush_reqs) begin
            // Abandon a request not yet accepted
            mem_arvalid <= 1'b0;
        end else if (issue) begin
            mem_arvalid <= 1'b1;
        end else if (mem_arready) begin
            mem_arvalid <= 1'b0;
        end
    end

    // Block aligned address, ID of the missed request
    always_ff @(posedge aclk) begin
        if (issue) begin
            mem_araddr <= lk.lk_addr & ~OFFSET_MASK;
            mem_arid   <= lk.lk_id;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Loading flag
    //////////////////////////////////////////////////////////////////

    // Set on the handshake, held across a flush until the refill lands
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            lk.loading <= 1'b0;
        end else if (mem_arvalid && mem_arready) begin
            lk.loading <= 1'b1;
        end else if (lk.fill) begin
            lk.loading <= 1'b0;
        end
    end

endmodule

/* verilog/block_fetcher.sv */
//////////////////////////////////////////////////////////////////////
// Instruction cache block fetcher top level
//////////////////////////////////////////////////////////////////////

module block_fetcher
    import fetch_pkg::*;
#(
    // Outstanding requests in the input FIFO, power of two
    parameter int OSTDREQ_NUM = 4,
    // Missed request FIFO depth, power of two
    parameter int MF_DEPTH    = 8
)(
    input  logic   aclk,
    input  logic   aresetn,
    // Control
    input  logic   flush_reqs,
    output logic   pending_rd,
    // Instruction read requests
    input  logic   arvalid,
    output logic   arready,
    input  addr_t  araddr,
    input  id_t    arid,
    // Responses
    output logic   rvalid,
    input  logic   rready,
    output id_t    rid,
    output instr_t rdata,
    // Cache read port
    output logic   cache_ren,
    output addr_t  cache_raddr,
    input  instr_t cache_rdata,
    input  logic   cache_hit,
    input  logic   cache_miss,
    input  logic   cache_writing,
    // Memory controller read request
    output logic   mem_arvalid,
    input  logic   mem_arready,
    output addr_t  mem_araddr,
    output id_t    mem_arid
);

    lookup_if lk ();

    // Cache answers and refill strobe
    assign lk.hit  = cache_hit;
    assign lk.miss = cache_miss;
    assign lk.fill = cache_writing;

    fetch_sequencer #(
        .OSTDREQ_NUM (OSTDREQ_NUM),
        .MF_DEPTH    (MF_DEPTH)
    ) i_fetch_sequencer (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .flush_reqs  (flush_reqs),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arid        (arid),
        .rready      (rready),
        .cache_ren   (cache_ren),
        .cache_raddr (cache_raddr),
        .pending_rd  (pending_rd),
        .lk          (lk)
    );

    read_completion i_read_completion (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .rready      (rready),
        .cache_rdata (cache_rdata),
        .rvalid      (rvalid),
        .rid         (rid),
        .rdata       (rdata),
        .lk          (lk)
    );

    block_loader i_block_loader (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .flush_reqs  (flush_reqs),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_arid    (mem_arid),
        .lk          (lk)
    );

endmodule

/* tests/tb_block_fetcher.sv */
//////////////////////////////////////////////////////////////////////
// Trace driven testbench of the block fetcher, with a cache and
// memory model, random response stalls and in-order response checks
//////////////////////////////////////////////////////////////////////

module tb_block_fetcher
    import fetch_pkg::*;
();

    localparam int    TRACE_LEN   = 64;
    localparam int    WAIT_LIMIT  = 300;
    localparam addr_t OFFSET_MASK = addr_t'(BLOCK_BYTES - 1);

    // Expected response, in request order
    typedef struct packed {
        id_t    id;
        instr_t data;
    } resp_t;

    logic   aclk;
    logic   aresetn;
    logic   flush_reqs;
    logic   pending_rd;
    logic   arvalid;
    logic   arready;
    addr_t  araddr;
    id_t    arid;
    logic   rvalid;
    logic   rready;
    id_t    rid;
    instr_t rdata;
    logic   cache_ren;
    addr_t  cache_raddr;
    instr_t cache_rdata;
    logic   cache_hit;
    logic   cache_miss;
    logic   cache_writing;
    logic   mem_arvalid;
    logic   mem_arready;
    addr_t  mem_araddr;
    id_t    mem_arid;

    // Trace record is kind, address, ID or count, word
    logic [79:0] trace [TRACE_LEN];
    logic [31:0] lfsr_state = 32'h2996_1edf;
    string       test_name = "reset";
    resp_t       exp_q [$];
    instr_t      mem_words [addr_t];
    // ID of the first request seen for each block
    id_t         blk_first_id [addr_t];
    bit          blk_valid [addr_t];
    bit          blk_requested [addr_t];
    int          mem_req_count = 0;

    block_fetcher #(
        .OSTDREQ_NUM (4),
        .MF_DEPTH    (8)
    ) i_block_fetcher (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .flush_reqs    (flush_reqs),
        .pending_rd    (pending_rd),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .arid          (arid),
        .rvalid        (rvalid),
        .rready        (rready),
        .rid           (rid),
        .rdata         (rdata),
        .cache_ren     (cache_ren),
        .cache_raddr   (cache_raddr),
        .cache_rdata   (cache_rdata),
        .cache_hit     (cache_hit),
        .cache_miss    (cache_miss),
        .cache_writing (cache_writing),
        .mem_arvalid   (mem_arvalid),
        .mem_arready   (mem_arready),
        .mem_araddr    (mem_araddr),
        .mem_arid      (mem_arid)
    );

    always #20 aclk = ~aclk;

    //////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic int lfsr_bits(input int n);
        int value;
        value = 0;
        for (int k = 0; k < n; k++) begin
            value = (value << 1) | lfsr_bit();
        end
        return value;
    endfunction

    function automatic addr_t block_of(input addr_t a);
        return a & ~OFFSET_MASK;
    endfunction

    // Unlisted words read back as the inverted address
    function automatic instr_t word_at(input addr_t a);
        return mem_words.exists(a) ? mem_words[a] : ~a;
    endfunction

    function automatic string test_title(input logic [7:0] n);
        case (n)
            8'd1: return "hit return";
            8'd2: return "miss and refill";
            8'd3: return "order under misses";
            8'd4: return "back-pressure";
            8'd5: return "flush";
            default: return "unnamed";
        endcase
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s, %s: expected %h, actual %h",
                                test_name, what, expected, actual));
        end
    endtask

    // Called and returns 2 units after a rising edge
    task automatic send_request(input addr_t addr, input id_t id, input instr_t data);
        int   waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        arvalid = 1'b1;
        araddr = addr;
        arid = id;
        while (!accepted) begin
            @(negedge aclk);
            accepted = arready;
            waited++;
            if (accepted) begin
                exp_q.push_back('{id: id, data: data});
                // Blocks start invalid, so the first request to one misses
                if (!blk_first_id.exists(block_of(addr))) begin
                    blk_first_id[block_of(addr)] = id;
                end
            end else if (waited > WAIT_LIMIT) begin
                abort_run("request was not accepted before the timeout");
            end
            @(posedge aclk);
            #2;
        end
    endtask

    task automatic wait_drain();
        int   waited;
        logic done;
        waited = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge aclk);
            done = (exp_q.size() == 0) && !pending_rd;
            waited++;
            if (!done && waited > WAIT_LIMIT) begin
                abort_run("responses were not drained before the timeout");
            end
            @(posedge aclk);
            #2;
        end
    endtask

    task automatic run_flush(input int cycles);
        wait_drain();
        flush_reqs = 1'b1;
        repeat (cycles) begin
            @(negedge aclk);
            check_value("arready during flush", 0, arready);
            @(posedge aclk);
            #2;
        end
        flush_reqs = 1'b0;
        @(negedge aclk);
        check_value("pending_rd after flush", 0, pending_rd);
        @(posedge aclk);
        #2;
    endtask

    //////////////////////////////////////////////////////////////////
    // Cache, memory and response side
    //////////////////////////////////////////////////////////////////

    // Samples on the falling edge, drives 2 units after the rising one
    initial begin : cache_and_memory
        logic   ren_q;
        addr_t  raddr_q;
        addr_t  refill_blk;
        int     refill_wait;
        logic   stalled;
        id_t    stall_id;
        instr_t stall_data;
        resp_t  head;
        ren_q = 1'b0;
        raddr_q = '0;
        refill_blk = '0;
        refill_wait = 0;
        stalled = 1'b0;
        stall_id = '0;
        stall_data = '0;
        cache_rdata = '0;
        cache_hit = 1'b0;
        cache_miss = 1'b0;
        cache_writing = 1'b0;
        mem_arready = 1'b0;
        rready = 1'b0;
        forever begin
            @(negedge aclk);
            // Stalled response must not move
            if (stalled) begin
                check_value("rvalid held while stalled", 1, rvalid);
                check_value("rid held while stalled", stall_id, rid);
                check_value("rdata held while stalled", stall_data, rdata);
            end
            if (rvalid && rready) begin
                if (exp_q.size() == 0) begin
                    abort_run("a response came back with no request outstanding");
                end else begin
                    head = exp_q.pop_front();
                    check_value("response id", head.id, rid);
                    check_value("response data", head.data, rdata);
                end
            end
            stalled = rvalid && !rready;
            stall_id = rid;
            stall_data = rdata;
            // One block read per missed block, aligned, with the missing ID
            if (mem_arvalid && mem_arready) begin
                check_value("memory address offset", 0, mem_araddr & OFFSET_MASK);
                if (!blk_first_id.exists(mem_araddr)) begin
                    abort_run("a memory request named a block never requested");
                end else begin
                    check_value("memory id", blk_first_id[mem_araddr], mem_arid);
                end
                if (blk_requested.exists(mem_araddr)) begin
                    abort_run("the same block was requested from memory twice");
                end
                blk_requested[mem_araddr] = 1'b1;
                mem_req_count++;
                refill_blk = mem_araddr;
                refill_wait = 2 + lfsr_bits(3);
            end
            ren_q = cache_ren;
            raddr_q = cache_raddr;
            @(posedge aclk);
            #2;
            // Answer one cycle after the read
            cache_hit = ren_q && blk_valid.exists(block_of(raddr_q));
            cache_miss = ren_q && !cache_hit;
            if (ren_q) begin
                cache_rdata = word_at(raddr_q);
            end
            cache_writing = 1'b0;
            if (refill_wait > 0) begin
                refill_wait--;
                if (refill_wait == 0) begin
                    blk_valid[refill_blk] = 1'b1;
                    cache_writing = 1'b1;
                end
            end
            rready = lfsr_bit();
            mem_arready = lfsr_bit();
        end
    end

    //////////////////////////////////////////////////////////////////
    // Trace player
    //////////////////////////////////////////////////////////////////

    initial begin : run_trace
        logic [79:0] entry;
        logic [7:0]  kind;
        addr_t       addr;
        logic [7:0]  arg;
        instr_t      data;
        aclk = 1'b0;
        aresetn = 1'b0;
        flush_reqs = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        arid = '0;
        for (int i = 0; i < TRACE_LEN; i++) begin
            trace[i] = '0;
        end
        $readmemh("tests/fetch_trace.txt", trace);
        repeat (2) @(posedge aclk);
        #2;
        aresetn = 1'b1;
        @(negedge aclk);
        check_value("arready after reset", 1, arready);
        check_value("rvalid after reset", 0, rvalid);
        check_value("mem_arvalid after reset", 0, mem_arvalid);
        check_value("cache_ren after reset", 0, cache_ren);
        check_value("pending_rd after reset", 0, pending_rd);
        @(posedge aclk);
        #2;
        for (int i = 0; i < TRACE_LEN; i++) begin
            entry = trace[i];
            kind = entry[79:72];
            addr = entry[71:40];
            arg = entry[39:32];
            data = entry[31:0];
            // Zero kind ends the trace
            if (kind == 8'h00) begin
                break;
            end
            if (kind != 8'h02) begin
                arvalid = 1'b0;
            end
            case (kind)
                8'h01: mem_words[addr] = data;
                8'h02: send_request(addr, arg, data);
                8'h03: run_flush(arg);
                8'h04: begin
                    wait_drain();
                    test_name = test_title(arg);
                end
                default: abort_run("the trace holds an unknown record kind");
            endcase
        end
        arvalid = 1'b0;
        wait_drain();
        test_name = "miss and refill";
        check_value("memory request count", blk_first_id.num(), mem_req_count);
        $display("all tests passed");
        $finish;
    end

endmodule

/* tests/fetch_trace.txt */
// Columns kind_address_arg_word, kind 01 memory word, 02 request (arg ID, word expected)
// kind 03 flush (arg cycles), kind 04 start of test (arg test number)
01_00000100_00_00000113
01_00000104_00_00a00093
01_00000108_00_00b00113
01_0000010c_00_002081b3
01_00000200_00_fe010113
01_00000204_00_00812e23
01_00000310_00_00000513
01_00000400_00_00400593
01_00000404_00_00058513
04_00000000_02_00000000
02_00000100_01_00000113
04_00000000_01_00000000
02_00000104_02_00a00093
04_00000000_03_00000000
02_00000108_03_00b00113
02_00000200_04_fe010113
02_0000010c_05_002081b3
02_00000310_06_00000513
02_00000204_07_00812e23
04_00000000_04_00000000
02_00000100_08_00000113
02_00000400_09_00400593
02_00000104_0a_00a00093
02_00000404_0b_00058513
02_00000310_0c_00000513
04_00000000_05_00000000
03_00000000_03_00000000
02_00000200_0d_fe010113

/* filelist.f */
verilog/fetch_pkg.sv
verilog/lookup_if.sv
verilog/sync_fifo.sv
verilog/fetch_sequencer.sv
verilog/read_completion.sv
verilog/block_loader.sv
verilog/block_fetcher.sv
tests/tb_block_fetcher.sv

/* Bender.yml */
package:
  name: block_fetcher

sources:
  # RTL in compile order
  - files:
      - verilog/fetch_pkg.sv
      - verilog/lookup_if.sv
      - verilog/sync_fifo.sv
      - verilog/fetch_sequencer.sv
      - verilog/read_completion.sv
      - verilog/block_loader.sv
      - verilog/block_fetcher.sv
  # Testbench
  - target: test
    files:
      - tests/tb_block_fetcher.sv
